// ==== i2s_rx_cfg.svh ====
`ifndef I2S_RX_CFG_SVH
`define I2S_RX_CFG_SVH

// Width of one PCM channel sample
`define PCM_WIDTH 24

// Per-word bit counter, saturates at its all-ones value
`define BIT_COUNT_WIDTH 8

// Stereo frames held between deserializer and aligner
`define FIFO_DEPTH 4

// Synchronizer flops ahead of edge detection, at least 2
`define SYNC_STAGES 2

`endif

// ==== i2s_rx_pkg.sv ====
`include "i2s_rx_cfg.svh"

package i2s_rx_pkg;

    // Audio sample and word length
    typedef logic [`PCM_WIDTH-1:0]       pcm_sample_t;
    typedef logic [`BIT_COUNT_WIDTH-1:0] bit_count_t;

    // Register port
    typedef logic [1:0]  reg_addr_t;
    typedef logic [15:0] reg_data_t;

    typedef struct packed {
        logic      write;
        reg_addr_t addr;
        reg_data_t wdata;
    } reg_bus_t;

    // Frame as captured off the wire, words right-aligned
    typedef struct packed {
        pcm_sample_t left;
        bit_count_t  left_bits;
        pcm_sample_t right;
        bit_count_t  right_bits;
    } raw_frame_t;

    // Frame after left-justification
    typedef struct packed {
        pcm_sample_t left;
        pcm_sample_t right;
    } pcm_frame_t;

    // Control register, enable is bit 3
    typedef struct packed {
        logic enable;
        logic swap;
        logic mute_left;
        logic mute_right;
    } rx_ctrl_t;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_LEFT,
        LEFT,
        RIGHT
    } deser_state_t;

endpackage

// ==== i2s_pin_sync.sv ====
`timescale 1ns/1ps
`include "i2s_rx_cfg.svh"

module i2s_pin_sync (
    input  logic clk,
    input  logic rst_n,
    input  logic bclk,
    input  logic lrclk,
    input  logic i2s_data,
    output logic bit_strobe,
    output logic ws,
    output logic sd
);

    logic [`SYNC_STAGES-1:0] bclk_sync;
    logic [`SYNC_STAGES-1:0] lrclk_sync;
    logic [`SYNC_STAGES-1:0] data_sync;
    logic                    bclk_last;
    logic                    bclk_rise;

    // Same depth on all three pins keeps them aligned in time
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bclk_sync  <= '0;
            lrclk_sync <= '0;
            data_sync  <= '0;
            bclk_last  <= 1'b0;
        end else begin
            bclk_sync  <= {bclk_sync[`SYNC_STAGES-2:0], bclk};
            lrclk_sync <= {lrclk_sync[`SYNC_STAGES-2:0], lrclk};
            data_sync  <= {data_sync[`SYNC_STAGES-2:0], i2s_data};
            bclk_last  <= bclk_sync[`SYNC_STAGES-1];
        end
    end

    assign bclk_rise = bclk_sync[`SYNC_STAGES-1] && !bclk_last;

    // Word select and data captured at the bclk rise
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_strobe <= 1'b0;
            ws         <= 1'b0;
            sd         <= 1'b0;
        end else begin
            bit_strobe <= bclk_rise;
            if (bclk_rise) begin
                ws <= lrclk_sync[`SYNC_STAGES-1];
                sd <= data_sync[`SYNC_STAGES-1];
            end
        end
    end

endmodule

// ==== i2s_frame_deserializer.sv ====
`timescale 1ns/1ps
`include "i2s_rx_cfg.svh"

module i2s_frame_deserializer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   bit_strobe,
    input  logic                   ws,
    input  logic                   sd,
    input  i2s_rx_pkg::rx_ctrl_t   ctrl,
    output logic                   raw_valid,
    output i2s_rx_pkg::raw_frame_t raw_frame,
    output logic                   word_done,
    output i2s_rx_pkg::bit_count_t word_bits
);

    import i2s_rx_pkg::*;

    localparam bit_count_t KEEP_BITS = bit_count_t'(`PCM_WIDTH);

    deser_state_t state;
    deser_state_t state_next;
    logic         ws_last;
    logic         ws_change;
    logic         word_end;
    logic         word_start;
    bit_count_t   bit_cnt;
    pcm_sample_t  shift_reg;

    ////////////////////////////////////////////////////////////////////////////
    // Word boundaries

    assign ws_change = bit_strobe && (ws != ws_last);
    assign word_end  = ctrl.enable && ws_change && (state == LEFT || state == RIGHT);

    // First bit of a word arrives on the strobe that carries the new ws
    assign word_start = word_end ||
                        (ctrl.enable && ws_change && !ws && state == WAIT_LEFT);

    always_comb begin
        state_next = state;
        if (!ctrl.enable) begin
            state_next = IDLE;
        end else begin
            case (state)
                IDLE:      state_next = WAIT_LEFT;
                WAIT_LEFT: if (ws_change && !ws) state_next = LEFT;
                LEFT:      if (ws_change) state_next = RIGHT;
                RIGHT:     if (ws_change) state_next = LEFT;
                default:   state_next = IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            ws_last   <= 1'b0;
            bit_cnt   <= '0;
            raw_valid <= 1'b0;
            word_done <= 1'b0;
        end else begin
            state     <= state_next;
            raw_valid <= word_end && (state == RIGHT);
            word_done <= word_end;
            if (bit_strobe) begin
                ws_last <= ws;
            end
            // Saturates at 255 for very long words
            if (word_start) begin
                bit_cnt <= bit_count_t'(1);
            end else if (bit_strobe && bit_cnt != '1) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Shift register and frame capture

    always_ff @(posedge clk) begin
        if (word_start) begin
            shift_reg <= pcm_sample_t'(sd);
        end else if (bit_strobe && bit_cnt < KEEP_BITS) begin
            shift_reg <= {shift_reg[`PCM_WIDTH-2:0], sd};
        end
        if (word_end) begin
            word_bits <= bit_cnt;
            if (state == LEFT) begin
                raw_frame.left      <= shift_reg;
                raw_frame.left_bits <= bit_cnt;
            end else begin
                raw_frame.right      <= shift_reg;
                raw_frame.right_bits <= bit_cnt;
            end
        end
    end

endmodule

// ==== pcm_frame_fifo.sv ====
`timescale 1ns/1ps
`include "i2s_rx_cfg.svh"

module pcm_frame_fifo (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   push,
    input  i2s_rx_pkg::raw_frame_t push_frame,
    input  logic                   pop_ready,
    output logic                   pop_valid,
    output i2s_rx_pkg::raw_frame_t pop_frame,
    output logic                   drop
);

    import i2s_rx_pkg::*;

    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

    localparam logic [PTR_W-1:0] LAST_SLOT  = PTR_W'(`FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(`FIFO_DEPTH);

    raw_frame_t       mem [`FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full      = (count == FULL_COUNT);
    assign pop_valid = (count != '0);
    assign pop_frame = mem[rd_ptr];

    // Serial side cannot wait, so a push into a full buffer is lost
    assign do_push = push && !full;
    assign drop    = push && full;
    assign do_pop  = pop_valid && pop_ready;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_frame;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== pcm_word_aligner.sv ====
`timescale 1ns/1ps
`include "i2s_rx_cfg.svh"

module pcm_word_aligner (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  i2s_rx_pkg::raw_frame_t in_frame,
    input  i2s_rx_pkg::rx_ctrl_t   ctrl,
    input  logic                   out_ready,
    output logic                   in_ready,
    output logic                   out_valid,
    output i2s_rx_pkg::pcm_frame_t out_data
);

    import i2s_rx_pkg::*;

    localparam bit_count_t FULL_BITS = bit_count_t'(`PCM_WIDTH);

    pcm_sample_t left_al;
    pcm_sample_t right_al;
    pcm_frame_t  next_data;

    // Short words sit in the low bits, move them up to the MSB
    function automatic pcm_sample_t justify(pcm_sample_t sample, bit_count_t bits);
        pcm_sample_t result;
        if (bits >= FULL_BITS) begin
            result = sample;
        end else begin
            result = sample << (FULL_BITS - bits);
        end
        return result;
    endfunction

    always_comb begin
        left_al  = justify(in_frame.left, in_frame.left_bits);
        right_al = justify(in_frame.right, in_frame.right_bits);
        // Swap first, then mute acts on the output channel
        next_data.left  = ctrl.swap ? right_al : left_al;
        next_data.right = ctrl.swap ? left_al : right_al;
        if (ctrl.mute_left) begin
            next_data.left = '0;
        end
        if (ctrl.mute_right) begin
            next_data.right = '0;
        end
    end

    // Output register empty or draining this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= next_data;
        end
    end

endmodule

// ==== i2s_rx_regs.sv ====
`timescale 1ns/1ps

module i2s_rx_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  i2s_rx_pkg::reg_bus_t   reg_bus,
    input  logic                   word_done,
    input  i2s_rx_pkg::bit_count_t word_bits,
    input  logic                   drop,
    output i2s_rx_pkg::reg_data_t  reg_rdata,
    output i2s_rx_pkg::rx_ctrl_t   ctrl
);

    import i2s_rx_pkg::*;

    localparam reg_addr_t ADDR_CTRL   = 2'd0;
    localparam reg_addr_t ADDR_STATUS = 2'd1;
    localparam reg_addr_t ADDR_DROPS  = 2'd2;

    bit_count_t last_bits;
    reg_data_t  drop_count;
    logic       drop_clear;

    assign drop_clear = reg_bus.write && reg_bus.addr == ADDR_DROPS;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl       <= '0;
            last_bits  <= '0;
            drop_count <= '0;
        end else begin
            if (reg_bus.write && reg_bus.addr == ADDR_CTRL) begin
                ctrl <= rx_ctrl_t'(reg_bus.wdata[3:0]);
            end
            if (word_done) begin
                last_bits <= word_bits;
            end
            // Clear beats a drop in the same cycle
            if (drop_clear) begin
                drop_count <= '0;
            end else if (drop && drop_count != '1) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

    // Read port
    always_comb begin
        case (reg_bus.addr)
            ADDR_CTRL:   reg_rdata = reg_data_t'(ctrl);
            ADDR_STATUS: reg_rdata = reg_data_t'(last_bits);
            ADDR_DROPS:  reg_rdata = drop_count;
            default:     reg_rdata = '0;
        endcase
    end

endmodule

// ==== i2s_rx_top.sv ====
`timescale 1ns/1ps

module i2s_rx_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   bclk,
    input  logic                   lrclk,
    input  logic                   i2s_data,
    input  i2s_rx_pkg::reg_bus_t   reg_bus,
    input  logic                   pcm_ready,
    output i2s_rx_pkg::reg_data_t  reg_rdata,
    output logic                   pcm_valid,
    output i2s_rx_pkg::pcm_frame_t pcm_data
);

    import i2s_rx_pkg::*;

    logic       bit_strobe;
    logic       ws;
    logic       sd;
    rx_ctrl_t   ctrl;
    logic       raw_valid;
    raw_frame_t raw_frame;
    logic       word_done;
    bit_count_t word_bits;
    logic       fifo_valid;
    logic       fifo_ready;
    raw_frame_t fifo_frame;
    logic       drop;

    ////////////////////////////////////////////////////////////////////////////
    // Serial front end

    i2s_pin_sync u_pin_sync (
        .clk        (clk),
        .rst_n      (rst_n),
        .bclk       (bclk),
        .lrclk      (lrclk),
        .i2s_data   (i2s_data),
        .bit_strobe (bit_strobe),
        .ws         (ws),
        .sd         (sd)
    );

    i2s_frame_deserializer u_deser (
        .clk        (clk),
        .rst_n      (rst_n),
        .bit_strobe (bit_strobe),
        .ws         (ws),
        .sd         (sd),
        .ctrl       (ctrl),
        .raw_valid  (raw_valid),
        .raw_frame  (raw_frame),
        .word_done  (word_done),
        .word_bits  (word_bits)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Frame buffer and PCM output

    pcm_frame_fifo u_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (raw_valid),
        .push_frame (raw_frame),
        .pop_ready  (fifo_ready),
        .pop_valid  (fifo_valid),
        .pop_frame  (fifo_frame),
        .drop       (drop)
    );

    pcm_word_aligner u_aligner (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (fifo_valid),
        .in_frame  (fifo_frame),
        .ctrl      (ctrl),
        .out_ready (pcm_ready),
        .in_ready  (fifo_ready),
        .out_valid (pcm_valid),
        .out_data  (pcm_data)
    );

    i2s_rx_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_bus   (reg_bus),
        .word_done (word_done),
        .word_bits (word_bits),
        .drop      (drop),
        .reg_rdata (reg_rdata),
        .ctrl      (ctrl)
    );

endmodule

// ==== i2s_rx_assertions.sv ====
`timescale 1ns/1ps
`include "i2s_rx_cfg.svh"

module i2s_rx_assertions (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   pcm_valid,
    input logic                   pcm_ready,
    input i2s_rx_pkg::pcm_frame_t pcm_data,
    input logic                   push,
    input logic                   fifo_valid,
    input logic                   fifo_ready,
    input logic                   drop
);

    localparam int DEPTH = `FIFO_DEPTH;

    int assert_failures = 0;
    int level;

    // Shadow occupancy of the frame FIFO
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            level <= 0;
        end else begin
            level <= level + ((push && level < DEPTH) ? 1 : 0)
                           - ((fifo_valid && fifo_ready) ? 1 : 0);
        end
    end

    // Output stays quiet in reset
    reset_quiet: assert property (@(posedge clk) !rst_n |-> !pcm_valid)
        else begin
            assert_failures++;
            $error("pcm_valid high during reset");
        end

    // Held frame must not change under back-pressure
    hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        pcm_valid && !pcm_ready |=> pcm_valid && $stable(pcm_data))
        else begin
            assert_failures++;
            $error("pcm_data changed or pcm_valid dropped before the transfer");
        end

    drop_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        drop |-> level == DEPTH)
        else begin
            assert_failures++;
            $error("frame dropped while the FIFO had room");
        end

endmodule

bind i2s_rx_top i2s_rx_assertions u_asrt (
    .clk        (clk),
    .rst_n      (rst_n),
    .pcm_valid  (pcm_valid),
    .pcm_ready  (pcm_ready),
    .pcm_data   (pcm_data),
    .push       (raw_valid),
    .fifo_valid (fifo_valid),
    .fifo_ready (fifo_ready),
    .drop       (drop)
);

// ==== tb_i2s_rx.sv ====
`timescale 1ns/1ps
`include "i2s_rx_cfg.svh"

module tb_i2s_rx;

    import i2s_rx_pkg::*;

    localparam int WAIT_LIMIT  = 4000;
    localparam int POLL_LIMIT  = 200;
    localparam int QUIET_SPAN  = 600;
    localparam int BP_FRAMES   = 7;
    localparam logic [3:0] CTRL_MODES [4] = '{4'b1100, 4'b1010, 4'b1001, 4'b1110};

    // Words as sent on the wire with the value in the low bits
    typedef struct packed {
        logic [31:0] left;
        bit_count_t  left_bits;
        logic [31:0] right;
        bit_count_t  right_bits;
    } wire_frame_t;

    logic        clk;
    logic        rst_n;
    logic        bclk;
    logic        lrclk;
    logic        i2s_data;
    reg_bus_t    reg_bus;
    logic        pcm_ready;
    reg_data_t   reg_rdata;
    logic        pcm_valid;
    pcm_frame_t  pcm_data;

    pcm_frame_t  exp_q[$];
    string       cur_test = "reset";
    int          errors = 0;
    int          checks = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    i2s_rx_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .bclk      (bclk),
        .lrclk     (lrclk),
        .i2s_data  (i2s_data),
        .reg_bus   (reg_bus),
        .pcm_ready (pcm_ready),
        .reg_rdata (reg_rdata),
        .pcm_valid (pcm_valid),
        .pcm_data  (pcm_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model

    function automatic logic [31:0] word_mask(int bits);
        return (bits >= 32) ? 32'hffff_ffff : ((32'h1 << bits) - 32'h1);
    endfunction

    function automatic wire_frame_t random_frame(int lbits, int rbits);
        wire_frame_t f;
        f.left       = $urandom & word_mask(lbits);
        f.left_bits  = bit_count_t'(lbits);
        f.right      = $urandom & word_mask(rbits);
        f.right_bits = bit_count_t'(rbits);
        return f;
    endfunction

    function automatic pcm_frame_t expected_frame(wire_frame_t f, rx_ctrl_t c);
        int          lbits;
        int          rbits;
        pcm_sample_t l;
        pcm_sample_t r;
        pcm_frame_t  e;
        lbits = int'(f.left_bits);
        rbits = int'(f.right_bits);
        // Long words keep their first bits and short ones move up to the MSB
        if (lbits >= `PCM_WIDTH) begin
            l = pcm_sample_t'(f.left >> (lbits - `PCM_WIDTH));
        end else begin
            l = pcm_sample_t'(f.left << (`PCM_WIDTH - lbits));
        end
        if (rbits >= `PCM_WIDTH) begin
            r = pcm_sample_t'(f.right >> (rbits - `PCM_WIDTH));
        end else begin
            r = pcm_sample_t'(f.right << (`PCM_WIDTH - rbits));
        end
        e.left  = c.swap ? r : l;
        e.right = c.swap ? l : r;
        if (c.mute_left) begin
            e.left = '0;
        end
        if (c.mute_right) begin
            e.right = '0;
        end
        return e;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checks and output monitor

    task automatic check_frame(input string name, input pcm_frame_t exp, input pcm_frame_t act);
        checks++;
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_reg(input string name, input reg_data_t exp, input reg_data_t act);
        checks++;
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (rst_n && pcm_valid && pcm_ready) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected output frame %h in test %s", pcm_data, cur_test);
                errors++;
            end else begin
                check_frame(cur_test, exp_q.pop_front(), pcm_data);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Serial and register stimulus

    // One bit takes 8 clk with data set while bclk is low
    task automatic send_bit(input logic ws_lvl, input logic bit_val);
        @(negedge clk);
        bclk     = 1'b0;
        lrclk    = ws_lvl;
        i2s_data = bit_val;
        repeat (4) @(negedge clk);
        bclk = 1'b1;
        repeat (3) @(negedge clk);
    endtask

    task automatic send_frame(input wire_frame_t f);
        for (int i = int'(f.left_bits) - 1; i >= 0; i--) begin
            send_bit(1'b0, f.left[i]);
        end
        for (int i = int'(f.right_bits) - 1; i >= 0; i--) begin
            send_bit(1'b1, f.right[i]);
        end
    endtask

    // Discarded by the receiver while it waits for a ws fall
    task automatic send_leading_frame();
        send_frame('{32'h0, 8'd24, 32'h0, 8'd24});
    endtask

    // The ws fall that closes the last right word
    task automatic send_trailer();
        send_bit(1'b0, 1'b0);
    endtask

    task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
        @(negedge clk);
        reg_bus = '{write: 1'b1, addr: addr, wdata: data};
        @(negedge clk);
        reg_bus.write = 1'b0;
    endtask

    task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
        @(negedge clk);
        reg_bus.write = 1'b0;
        reg_bus.addr  = addr;
        @(negedge clk);
        data = reg_rdata;
    endtask

    // Disable first so any partial word is thrown away
    task automatic start_rx(input rx_ctrl_t c);
        reg_write(2'd0, 16'h0000);
        reg_write(2'd0, reg_data_t'(c));
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout in %s, %0d frames never arrived", cur_test, exp_q.size());
            errors++;
            exp_q.delete();
        end
    endtask

    task automatic wait_drop_count(input reg_data_t target);
        reg_data_t rd;
        int        polls;
        rd    = '0;
        polls = 0;
        while (rd != target && polls < POLL_LIMIT) begin
            reg_read(2'd2, rd);
            polls++;
        end
        check_reg(cur_test, target, rd);
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_errors) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d error(s)", cur_test, errors - test_errors);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests

    task automatic stream_full_words();
        rx_ctrl_t    c;
        wire_frame_t f;
        c = 4'b1000;
        begin_test("full_words");
        start_rx(c);
        send_leading_frame();
        for (int i = 0; i < 5; i++) begin
            // Last frame carries 32-bit words
            f = (i == 4) ? random_frame(32, 32) : random_frame(24, 24);
            exp_q.push_back(expected_frame(f, c));
            send_frame(f);
        end
        send_trailer();
        wait_drained();
        end_test();
    endtask

    task automatic stream_short_words();
        rx_ctrl_t    c;
        wire_frame_t f;
        reg_data_t   rd;
        c = 4'b1000;
        begin_test("short_words");
        start_rx(c);
        send_leading_frame();
        for (int i = 0; i < 6; i++) begin
            f = random_frame(($urandom & 1) ? 16 : 20, ($urandom & 1) ? 16 : 20);
            exp_q.push_back(expected_frame(f, c));
            send_frame(f);
        end
        send_trailer();
        wait_drained();
        reg_read(2'd1, rd);
        check_reg(cur_test, reg_data_t'(f.right_bits), rd);
        end_test();
    endtask

    task automatic sweep_ctrl_modes();
        rx_ctrl_t    c;
        wire_frame_t f;
        reg_data_t   rd;
        begin_test("ctrl_modes");
        for (int m = 0; m < 4; m++) begin
            c = rx_ctrl_t'(CTRL_MODES[m]);
            start_rx(c);
            reg_read(2'd0, rd);
            check_reg(cur_test, reg_data_t'(c), rd);
            send_leading_frame();
            for (int i = 0; i < 2; i++) begin
                f = random_frame(24, (i == 0) ? 16 : 24);
                exp_q.push_back(expected_frame(f, c));
                send_frame(f);
            end
            send_trailer();
            wait_drained();
        end
        end_test();
    endtask

    task automatic fill_under_backpressure();
        rx_ctrl_t    c;
        wire_frame_t f;
        reg_data_t   rd;
        c = 4'b1000;
        begin_test("backpressure");
        @(negedge clk);
        pcm_ready = 1'b0;
        start_rx(c);
        send_leading_frame();
        for (int i = 0; i < BP_FRAMES; i++) begin
            f = random_frame(24, 24);
            // One frame waits in the aligner and the rest in the FIFO
            if (i <= `FIFO_DEPTH) begin
                exp_q.push_back(expected_frame(f, c));
            end
            send_frame(f);
        end
        send_trailer();
        wait_drop_count(reg_data_t'(BP_FRAMES - `FIFO_DEPTH - 1));
        @(negedge clk);
        pcm_ready = 1'b1;
        wait_drained();
        reg_write(2'd2, 16'h0000);
        reg_read(2'd2, rd);
        check_reg(cur_test, 16'h0000, rd);
        end_test();
    endtask

    task automatic ignore_while_disabled();
        rx_ctrl_t    c;
        wire_frame_t f;
        int          cycles;
        logic        seen;
        c = 4'b0000;
        begin_test("disabled");
        start_rx(c);
        send_leading_frame();
        send_frame(random_frame(24, 24));
        send_frame(random_frame(24, 24));
        send_trailer();
        cycles = 0;
        seen   = 1'b0;
        while (cycles < QUIET_SPAN) begin
            @(negedge clk);
            if (pcm_valid) begin
                seen = 1'b1;
            end
            cycles++;
        end
        if (seen) begin
            $display("pcm_valid went high in %s while the receiver was disabled", cur_test);
            errors++;
        end
        c = 4'b1000;
        start_rx(c);
        send_leading_frame();
        f = random_frame(24, 24);
        exp_q.push_back(expected_frame(f, c));
        send_frame(f);
        send_trailer();
        wait_drained();
        end_test();
    endtask

    initial begin
        void'($urandom(32'hb8da8d2e));
        rst_n      = 1'b0;
        bclk       = 1'b0;
        lrclk      = 1'b0;
        i2s_data   = 1'b0;
        reg_bus    = '0;
        pcm_ready  = 1'b1;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        stream_full_words();
        stream_short_words();
        sweep_ctrl_modes();
        fill_under_backpressure();
        ignore_while_disabled();
        errors = errors + dut0.u_asrt.assert_failures;
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+.
i2s_rx_pkg.sv
i2s_pin_sync.sv
i2s_frame_deserializer.sv
pcm_frame_fifo.sv
pcm_word_aligner.sv
i2s_rx_regs.sv
i2s_rx_top.sv
i2s_rx_assertions.sv
tb_i2s_rx.sv

// ==== Makefile ====
# Verilator flow for the I2S receiver testbench

VERILATOR ?= verilator
TOP       ?= tb_i2s_rx
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

FAIL_MSG  := Regression failed
PASS_MSG  := Regression passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The log decides the result, an aborted run has no pass line
sim: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
